/* Makefile */
# Verilator flow for the FP32 non-computational FPU
TOP := tb_fpu_noncomp

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -Wno-fatal --top-module $(TOP) -f src.f -o $(TOP)

# Passes only when the simulation prints the pass message
run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

/* logic/fpu_issue_hold.sv */
/*
 * Upstream protocol inversion buffer.
 * The issuer sees ready before the unit is asked; on a stall the
 * instruction is parked here and ready is withdrawn for that cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_issue_hold (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  logic                 valid_i,
    input  fpu_pkg::noncomp_op_e noncomp_op_i,
    input  fpu_pkg::sub_op_t     sub_op_i,
    input  fpu_pkg::fp_word_t    operand_a_i,
    input  fpu_pkg::fp_word_t    operand_b_i,
    input  fpu_pkg::trans_id_t   trans_id_i,
    input  logic                 exec_ready_i,
    output logic                 ready_o,
    output logic                 exec_valid_o,
    output fpu_pkg::noncomp_op_e noncomp_op_o,
    output fpu_pkg::sub_op_t     sub_op_o,
    output fpu_pkg::fp_word_t    operand_a_o,
    output fpu_pkg::fp_word_t    operand_b_o,
    output fpu_pkg::trans_id_t   trans_id_o
);
    import fpu_pkg::*;

    typedef enum logic {READY, STALL} hold_state_e;

    hold_state_e state_q, state_d;
    logic        hold_inputs;       // Load enable of the hold register
    logic        use_hold;          // Feed execute from the hold register

    noncomp_op_e op_q;
    sub_op_t     sub_op_q;
    fp_word_t    operand_a_q, operand_b_q;
    trans_id_t   trans_id_q;

    // ------------------------------------------------------------------
    // READY / STALL FSM
    // ------------------------------------------------------------------
    always_comb begin : p_hold_fsm
        ready_o      = 1'b0;
        exec_valid_o = 1'b0;
        hold_inputs  = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        unique case (state_q)
            READY: begin
                ready_o      = 1'b1;        // Token offered up front
                exec_valid_o = valid_i;     // Straight through
                if (valid_i && !exec_ready_i) begin
                    ready_o     = 1'b0;     // Take the token back
                    hold_inputs = 1'b1;     // Park the instruction
                    state_d     = STALL;
                end
            end
            STALL: begin
                exec_valid_o = 1'b1;        // Parked instruction pending
                use_hold     = 1'b1;
                if (exec_ready_i) begin
                    ready_o = 1'b1;
                    state_d = READY;
                end
            end
            default: ;
        endcase

        if (flush_i) state_d = READY;       // Drops the parked one too
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) state_q <= READY;
        else         state_q <= state_d;
    end

    // Hold register, payload only
    always_ff @(posedge clk_i) begin
        if (hold_inputs) begin
            op_q        <= noncomp_op_i;
            sub_op_q    <= sub_op_i;
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_i;
            trans_id_q  <= trans_id_i;
        end
    end

    // Input mux towards execute
    assign noncomp_op_o = use_hold ? op_q        : noncomp_op_i;
    assign sub_op_o     = use_hold ? sub_op_q    : sub_op_i;
    assign operand_a_o  = use_hold ? operand_a_q : operand_a_i;
    assign operand_b_o  = use_hold ? operand_b_q : operand_b_i;
    assign trans_id_o   = use_hold ? trans_id_q  : trans_id_i;

endmodule

`default_nettype wire

/* logic/fpu_noncomp_exec.sv */
/*
 * FP32 sign injection, min/max, compare and classify, followed by
 * NUM_PIPE_REGS valid/ready stage registers (1 or more).
 * -0 orders below +0 for min/max but compares equal in FCMP.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_noncomp_exec #(
    parameter int unsigned NUM_PIPE_REGS = 1
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  logic                 in_valid_i,
    input  fpu_pkg::noncomp_op_e noncomp_op_i,
    input  fpu_pkg::sub_op_t     sub_op_i,
    input  fpu_pkg::fp_word_t    operand_a_i,
    input  fpu_pkg::fp_word_t    operand_b_i,
    input  fpu_pkg::trans_id_t   trans_id_i,
    input  logic                 out_ready_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output fpu_pkg::fp_word_t    value_o,
    output fpu_pkg::fp_status_t  status_o,
    output fpu_pkg::trans_id_t   trans_id_o
);
    import fpu_pkg::*;

    // One-hot class of an FP32 pattern
    function automatic logic [9:0] fp_class(fp_word_t x);
        logic [9:0] cls;
        logic       exp_ones, exp_zero, man_zero;
        exp_ones = &x[30:23];
        exp_zero = ~|x[30:23];
        man_zero = ~|x[22:0];
        cls      = '0;
        if (exp_ones && !man_zero) begin
            if (x[22]) cls[CLASS_QNAN] = 1'b1;   // Quiet bit set
            else       cls[CLASS_SNAN] = 1'b1;
        end else if (exp_ones) begin
            cls[x[31] ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
        end else if (exp_zero && man_zero) begin
            cls[x[31] ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            cls[x[31] ? CLASS_NEG_SUB : CLASS_POS_SUB] = 1'b1;
        end else begin
            cls[x[31] ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
        end
        return cls;
    endfunction

    // ------------------------------------------------------------------
    // Operand analysis
    // ------------------------------------------------------------------
    logic [9:0] a_cls, b_cls;
    logic       a_nan, b_nan, any_nan, any_snan, both_zero;
    logic       a_lt_b, a_eq_b;        // Total order, -0 < +0

    assign a_cls     = fp_class(operand_a_i);
    assign b_cls     = fp_class(operand_b_i);
    assign a_nan     = a_cls[CLASS_SNAN] | a_cls[CLASS_QNAN];
    assign b_nan     = b_cls[CLASS_SNAN] | b_cls[CLASS_QNAN];
    assign any_nan   = a_nan | b_nan;
    assign any_snan  = a_cls[CLASS_SNAN] | b_cls[CLASS_SNAN];
    assign both_zero = (a_cls[CLASS_NEG_ZERO] | a_cls[CLASS_POS_ZERO])
                     & (b_cls[CLASS_NEG_ZERO] | b_cls[CLASS_POS_ZERO]);
    assign a_eq_b    = (operand_a_i == operand_b_i);

    // Sign-magnitude ordering
    always_comb begin
        if (operand_a_i[31] != operand_b_i[31]) a_lt_b = operand_a_i[31];
        else if (operand_a_i[31])               a_lt_b = operand_a_i[30:0] > operand_b_i[30:0];
        else                                    a_lt_b = operand_a_i[30:0] < operand_b_i[30:0];
    end

    // ------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------
    fp_word_t   res_value;
    fp_status_t res_status;

    always_comb begin : op_select
        res_value  = operand_a_i;
        res_status = '0;
        unique case (noncomp_op_i)
            SGNJ: begin
                unique case (sub_op_i)
                    2'd0:    res_value = {operand_b_i[31], operand_a_i[30:0]};
                    2'd1:    res_value = {~operand_b_i[31], operand_a_i[30:0]};
                    2'd2:    res_value = {operand_a_i[31] ^ operand_b_i[31],
                                          operand_a_i[30:0]};
                    default: res_value = operand_a_i;    // Move passthrough
                endcase
            end
            MINMAX: begin
                res_status.nv = any_snan;
                if (a_nan && b_nan)  res_value = CANONICAL_NAN;
                else if (a_nan)      res_value = operand_b_i;
                else if (b_nan)      res_value = operand_a_i;
                else if (sub_op_i[0]) res_value = a_lt_b ? operand_b_i : operand_a_i; // Max
                else                  res_value = a_lt_b ? operand_a_i : operand_b_i; // Min
            end
            CMP: begin
                res_value = '0;
                unique case (sub_op_i)
                    2'd0: begin    // le
                        res_status.nv = any_nan;
                        res_value[0]  = ~any_nan & (a_lt_b | a_eq_b | both_zero);
                    end
                    2'd1: begin    // lt
                        res_status.nv = any_nan;
                        res_value[0]  = ~any_nan & a_lt_b & ~both_zero;
                    end
                    2'd2: begin    // eq, quiet NaN is not invalid
                        res_status.nv = any_snan;
                        res_value[0]  = ~any_nan & (a_eq_b | both_zero);
                    end
                    default: ;
                endcase
            end
            default: res_value = {{(FLEN-10){1'b0}}, a_cls};  // CLASSIFY
        endcase
    end

    // ------------------------------------------------------------------
    // Pipeline stages, bubbles collapse
    // ------------------------------------------------------------------
    logic       valid_q  [NUM_PIPE_REGS];
    logic       load     [NUM_PIPE_REGS];   // Stage accepts new content
    fp_word_t   value_q  [NUM_PIPE_REGS];
    fp_status_t status_q [NUM_PIPE_REGS];
    trans_id_t  tag_q    [NUM_PIPE_REGS];

    for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : g_stage
        logic       src_valid;
        fp_word_t   src_value;
        fp_status_t src_status;
        trans_id_t  src_tag;

        if (i == 0) begin : g_head
            assign src_valid  = in_valid_i;
            assign src_value  = res_value;
            assign src_status = res_status;
            assign src_tag    = trans_id_i;
        end else begin : g_body
            assign src_valid  = valid_q[i-1];
            assign src_value  = value_q[i-1];
            assign src_status = status_q[i-1];
            assign src_tag    = tag_q[i-1];
        end

        if (i == NUM_PIPE_REGS - 1) begin : g_last
            assign load[i] = ~valid_q[i] | out_ready_i;
        end else begin : g_mid
            assign load[i] = ~valid_q[i] | load[i+1];
        end

        always_ff @(posedge clk_i) begin
            if (reset_i || flush_i) valid_q[i] <= 1'b0;   // Kill in-flight
            else if (load[i])       valid_q[i] <= src_valid;
        end

        always_ff @(posedge clk_i) begin
            if (load[i] && src_valid) begin
                value_q[i]  <= src_value;
                status_q[i] <= src_status;
                tag_q[i]    <= src_tag;
            end
        end
    end

    assign in_ready_o  = load[0];
    assign out_valid_o = valid_q[NUM_PIPE_REGS-1];
    assign value_o     = value_q[NUM_PIPE_REGS-1];
    assign status_o    = status_q[NUM_PIPE_REGS-1];
    assign trans_id_o  = tag_q[NUM_PIPE_REGS-1];

endmodule

`default_nettype wire

/* logic/fpu_noncomp_top.sv */
/*
 * FP32 non-computational FPU: decode, hold buffer, execute, writeback.
 * Latency is NUM_PIPE_REGS+1 cycles without back-pressure, in order.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_noncomp_top #(
    parameter int unsigned NUM_PIPE_REGS = 1
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                flush_i,
    input  logic                fpu_valid_i,
    input  fpu_pkg::fu_op_e     operator_i,
    input  logic [2:0]          fpu_rm_i,
    input  fpu_pkg::fp_word_t   operand_a_i,
    input  fpu_pkg::fp_word_t   operand_b_i,
    input  fpu_pkg::trans_id_t  trans_id_i,
    input  logic                out_ready_i,
    output logic                fpu_ready_o,
    output logic                fpu_valid_o,
    output fpu_pkg::fp_word_t   result_o,
    output fpu_pkg::fp_status_t fpu_status_o,
    output fpu_pkg::trans_id_t  fpu_trans_id_o
);
    import fpu_pkg::*;

    // Decode outputs
    noncomp_op_e noncomp_op;
    sub_op_t     sub_op;

    // Hold buffer to execute
    logic        in_valid, in_ready;
    noncomp_op_e in_op;
    sub_op_t     in_sub_op;
    fp_word_t    in_operand_a, in_operand_b;
    trans_id_t   in_trans_id;

    // Execute to writeback
    logic        exec_valid, exec_ready;
    fp_word_t    exec_value;
    fp_status_t  exec_status;
    trans_id_t   exec_trans_id;

    fpu_op_decode i_decode (
        .operator_i   (operator_i),
        .fpu_rm_i     (fpu_rm_i),
        .noncomp_op_o (noncomp_op),
        .sub_op_o     (sub_op)
    );

    fpu_issue_hold i_hold (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .valid_i      (fpu_valid_i),
        .noncomp_op_i (noncomp_op),
        .sub_op_i     (sub_op),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .trans_id_i   (trans_id_i),
        .exec_ready_i (in_ready),
        .ready_o      (fpu_ready_o),
        .exec_valid_o (in_valid),
        .noncomp_op_o (in_op),
        .sub_op_o     (in_sub_op),
        .operand_a_o  (in_operand_a),
        .operand_b_o  (in_operand_b),
        .trans_id_o   (in_trans_id)
    );

    fpu_noncomp_exec #(
        .NUM_PIPE_REGS (NUM_PIPE_REGS)
    ) i_exec (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .in_valid_i   (in_valid),
        .noncomp_op_i (in_op),
        .sub_op_i     (in_sub_op),
        .operand_a_i  (in_operand_a),
        .operand_b_i  (in_operand_b),
        .trans_id_i   (in_trans_id),
        .out_ready_i  (exec_ready),
        .in_ready_o   (in_ready),
        .out_valid_o  (exec_valid),
        .value_o      (exec_value),
        .status_o     (exec_status),
        .trans_id_o   (exec_trans_id)
    );

    fpu_result_stage i_result (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .in_valid_i     (exec_valid),
        .value_i        (exec_value),
        .status_i       (exec_status),
        .trans_id_i     (exec_trans_id),
        .out_ready_i    (out_ready_i),
        .in_ready_o     (exec_ready),
        .fpu_valid_o    (fpu_valid_o),
        .result_o       (result_o),
        .fpu_status_o   (fpu_status_o),
        .fpu_trans_id_o (fpu_trans_id_o)
    );

endmodule

`default_nettype wire

/* logic/fpu_op_decode.sv */
/*
 * Operator decode, purely combinational.
 * rm[2] selects an alternate format in the core, which is not supported,
 * so it is masked off for every operator.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_op_decode (
    input  fpu_pkg::fu_op_e     operator_i,
    input  logic [2:0]          fpu_rm_i,
    output fpu_pkg::noncomp_op_e noncomp_op_o,
    output fpu_pkg::sub_op_t    sub_op_o
);
    import fpu_pkg::*;

    logic [1:0] rm_masked;   // AH bit dropped

    assign rm_masked = fpu_rm_i[1:0];

    // ------------------------------------------------------------------
    // Operator to opcode translation
    // ------------------------------------------------------------------
    always_comb begin : op_translation
        // Defaults give a plain passthrough
        noncomp_op_o = SGNJ;
        sub_op_o     = 2'd3;

        unique case (operator_i)
            // Sign injection variant comes from rm
            FSGNJ: begin
                noncomp_op_o = SGNJ;
                sub_op_o     = rm_masked;
            end
            FMIN_MAX: begin
                noncomp_op_o = MINMAX;          // rm 0 min, 1 max
                sub_op_o     = rm_masked;
            end
            FCMP: begin
                noncomp_op_o = CMP;             // rm 0 le, 1 lt, 2 eq
                sub_op_o     = rm_masked;
            end
            FCLASS: begin
                noncomp_op_o = CLASSIFY;        // sub-op ignored downstream
                sub_op_o     = rm_masked;
            end
            // Moves map to the SGNJ passthrough
            FMV_F2X,
            FMV_X2F: begin
                noncomp_op_o = SGNJ;
                sub_op_o     = 2'd3;
            end
            default: ;  // Keep passthrough
        endcase
    end

endmodule

`default_nettype wire

/* logic/fpu_pkg.sv */
/*
 * Shared types and constants of the FP32 non-computational unit.
 * Only single precision is supported, so FLEN is fixed at 32.
 * Only the NV status flag is ever raised by this unit.
 */
`default_nettype none

package fpu_pkg;

    // ------------------------------------------------------------------
    // Widths and basic types
    // ------------------------------------------------------------------
    localparam int unsigned FLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;   // Scoreboard tag
    typedef logic [FLEN-1:0]          fp_word_t;    // Raw FP32 pattern

    // Operator field as sent by the core
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } fu_op_e;

    // Opcodes of the execute stage
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } noncomp_op_e;

    typedef logic [1:0] sub_op_t;   // rm[1:0], AH bit dropped

    // Status flags, NV in the MSB as in fflags
    typedef struct packed {
        logic nv;   // Invalid operation
        logic dz;   // Divide by zero
        logic of;   // Overflow
        logic uf;   // Underflow
        logic nx;   // Inexact
    } fp_status_t;

    localparam fp_word_t CANONICAL_NAN = 32'h7FC0_0000;

    // ------------------------------------------------------------------
    // FCLASS mask bit positions, RISC-V order
    // ------------------------------------------------------------------
    localparam int unsigned CLASS_NEG_INF  = 0;
    localparam int unsigned CLASS_NEG_NORM = 1;
    localparam int unsigned CLASS_NEG_SUB  = 2;
    localparam int unsigned CLASS_NEG_ZERO = 3;
    localparam int unsigned CLASS_POS_ZERO = 4;
    localparam int unsigned CLASS_POS_SUB  = 5;
    localparam int unsigned CLASS_POS_NORM = 6;
    localparam int unsigned CLASS_POS_INF  = 7;
    localparam int unsigned CLASS_SNAN     = 8;
    localparam int unsigned CLASS_QNAN     = 9;

endpackage

`default_nettype wire

/* logic/fpu_result_stage.sv */
/*
 * Writeback register towards the core.
 * Outputs are stable while fpu_valid_o is high and out_ready_i is low.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_result_stage (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                flush_i,
    input  logic                in_valid_i,
    input  fpu_pkg::fp_word_t   value_i,
    input  fpu_pkg::fp_status_t status_i,
    input  fpu_pkg::trans_id_t  trans_id_i,
    input  logic                out_ready_i,
    output logic                in_ready_o,
    output logic                fpu_valid_o,
    output fpu_pkg::fp_word_t   result_o,
    output fpu_pkg::fp_status_t fpu_status_o,
    output fpu_pkg::trans_id_t  fpu_trans_id_o
);
    import fpu_pkg::*;

    logic       valid_q;
    fp_word_t   result_q;
    fp_status_t status_q;
    trans_id_t  tag_q;

    // Free, or being drained this cycle
    assign in_ready_o = ~valid_q | out_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) valid_q <= 1'b0;
        else if (in_ready_o)    valid_q <= in_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            result_q <= value_i;
            status_q <= status_i;
            tag_q    <= trans_id_i;
        end
    end

    assign fpu_valid_o    = valid_q;
    assign result_o       = result_q;
    assign fpu_status_o   = status_q;
    assign fpu_trans_id_o = tag_q;

endmodule

`default_nettype wire

/* src.f */
logic/fpu_pkg.sv
logic/fpu_op_decode.sv
logic/fpu_issue_hold.sv
logic/fpu_noncomp_exec.sv
logic/fpu_result_stage.sv
logic/fpu_noncomp_top.sv
tb/tb_fpu_noncomp.sv

/* tb/fpu_trace.txt */
# name operator rm operand_a operand_b expected_result expected_status
# rm in decimal, all values in hex, status 10 means NV set
sgnj_take_b      FSGNJ    0 3F800000 BF800000 BF800000 00
sgnjn_invert_b   FSGNJ    1 3F800000 BF800000 3F800000 00
sgnjx_xor        FSGNJ    2 BF800000 BF800000 3F800000 00
sgnj_snan_no_nv  FSGNJ    0 7FA00000 80000000 FFA00000 00
sgnjn_rm_msb     FSGNJ    5 40000000 00000000 C0000000 00
fmv_f2x_nan      FMV_F2X  0 7F800001 12345678 7F800001 00
fmv_x2f_raw      FMV_X2F  2 DEADBEEF 00000000 DEADBEEF 00
fmv_x2f_rm_msb   FMV_X2F  7 FFC00001 3F800000 FFC00001 00
min_normal       FMIN_MAX 0 3F800000 40000000 3F800000 00
max_normal       FMIN_MAX 1 3F800000 40000000 40000000 00
min_negative     FMIN_MAX 0 C0000000 BF800000 C0000000 00
min_signed_zero  FMIN_MAX 0 00000000 80000000 80000000 00
max_signed_zero  FMIN_MAX 1 80000000 00000000 00000000 00
min_qnan_a       FMIN_MAX 0 7FC00000 40400000 40400000 00
max_qnan_b       FMIN_MAX 1 C0400000 7FC00000 C0400000 00
min_snan_a       FMIN_MAX 0 7F800001 3F800000 3F800000 10
max_two_nan      FMIN_MAX 1 7FC00000 FF800001 7FC00000 10
min_rm_msb       FMIN_MAX 4 40400000 BF800000 BF800000 00
le_less          FCMP     0 3F800000 40000000 00000001 00
le_equal         FCMP     0 40000000 40000000 00000001 00
lt_equal         FCMP     1 40000000 40000000 00000000 00
lt_mixed_sign    FCMP     1 BF800000 3F800000 00000001 00
eq_signed_zero   FCMP     2 80000000 00000000 00000001 00
lt_signed_zero   FCMP     1 80000000 00000000 00000000 00
eq_qnan_quiet    FCMP     2 7FC00000 3F800000 00000000 00
le_qnan_invalid  FCMP     0 7FC00000 3F800000 00000000 10
eq_snan_invalid  FCMP     2 7F800001 7F800001 00000000 10
lt_rm_msb        FCMP     5 3F800000 40000000 00000001 00
class_neg_inf    FCLASS   0 FF800000 00000000 00000001 00
class_neg_norm   FCLASS   0 BF800000 00000000 00000002 00
class_neg_sub    FCLASS   0 80000001 00000000 00000004 00
class_neg_zero   FCLASS   0 80000000 00000000 00000008 00
class_pos_zero   FCLASS   0 00000000 00000000 00000010 00
class_pos_sub    FCLASS   0 007FFFFF 00000000 00000020 00
class_pos_norm   FCLASS   0 3F800000 00000000 00000040 00
class_pos_inf    FCLASS   0 7F800000 00000000 00000080 00
class_snan       FCLASS   0 7F800001 00000000 00000100 00
class_qnan_rm    FCLASS   4 7FC00000 00000000 00000200 00

/* tb/tb_fpu_noncomp.sv */
/*
 * Trace-driven testbench for fpu_noncomp_top with random back-pressure and flush.
 * Reads tb/fpu_trace.txt relative to the directory the simulator is started in.
 * Assumes at least NUM_PIPE_REGS+2 trace lines so the pipeline can be filled.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_noncomp;
    import fpu_pkg::*;

    localparam int unsigned NUM_PIPE_REGS = 2;
    localparam int          MAX_LINES     = 64;
    localparam int          WAIT_LIMIT    = 100;    // Cycles allowed per wait loop

    logic        clk;
    logic        reset_i, flush_i, fpu_valid_i, out_ready_i;
    fu_op_e      operator_i;
    logic [2:0]  fpu_rm_i;
    fp_word_t    operand_a_i, operand_b_i;
    trans_id_t   trans_id_i;
    logic        fpu_ready_o, fpu_valid_o;
    fp_word_t    result_o;
    fp_status_t  fpu_status_o;
    trans_id_t   fpu_trans_id_o;

    // Trace contents, one entry per data line
    string       t_name   [MAX_LINES];
    fu_op_e      t_op     [MAX_LINES];
    logic [2:0]  t_rm     [MAX_LINES];
    fp_word_t    t_a      [MAX_LINES];
    fp_word_t    t_b      [MAX_LINES];
    fp_word_t    t_result [MAX_LINES];
    fp_status_t  t_status [MAX_LINES];
    int          n_lines;

    int          exp_idx [$];       // Accepted instructions, oldest first
    trans_id_t   exp_tag [$];
    trans_id_t   next_tag;

    logic [19:0] lfsr_q;
    logic        hold_back;         // Forces out_ready_i low
    logic        timed_out;
    int          value_errors, other_errors, results_seen;

    fpu_noncomp_top #(
        .NUM_PIPE_REGS (NUM_PIPE_REGS)
    ) dut (
        .clk_i          (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .fpu_valid_i    (fpu_valid_i),
        .operator_i     (operator_i),
        .fpu_rm_i       (fpu_rm_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .trans_id_i     (trans_id_i),
        .out_ready_i    (out_ready_i),
        .fpu_ready_o    (fpu_ready_o),
        .fpu_valid_o    (fpu_valid_o),
        .result_o       (result_o),
        .fpu_status_o   (fpu_status_o),
        .fpu_trans_id_o (fpu_trans_id_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // ------------------------------------------------------------------
    // Random source and trace loading
    // ------------------------------------------------------------------
    // Fibonacci LFSR with taps 20 and 17
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[19] ^ lfsr_q[16];
        lfsr_q = {lfsr_q[18:0], fb};
        return fb;
    endfunction

    function automatic logic next_out_ready();
        logic b0, b1;
        if (hold_back) return 1'b0;
        b0 = lfsr_bit();
        b1 = lfsr_bit();
        return !(b0 && b1);         // Low one cycle in four
    endfunction

    function automatic int op_code(input string s);
        case (s)
            "FSGNJ":    return int'(FSGNJ);
            "FMIN_MAX": return int'(FMIN_MAX);
            "FCMP":     return int'(FCMP);
            "FCLASS":   return int'(FCLASS);
            "FMV_F2X":  return int'(FMV_F2X);
            "FMV_X2F":  return int'(FMV_X2F);
            default:    return -1;
        endcase
    endfunction

    task automatic load_trace();
        int       fd, fields, code, rm;
        string    line, name, op_name;
        fp_word_t a, b, res, st;
        n_lines = 0;
        fd = $fopen("tb/fpu_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tb/fpu_trace.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0 && n_lines < MAX_LINES) begin
            if (line.len() < 3 || line.getc(0) == "#") continue;   // Blank or comment
            fields = $sscanf(line, "%s %s %d %h %h %h %h", name, op_name, rm, a, b, res, st);
            code   = op_code(op_name);
            if (fields != 7 || code < 0) begin
                $display("Trace line could not be parsed: %s", line);
                other_errors++;
                continue;
            end
            t_name[n_lines]   = name;
            t_op[n_lines]     = fu_op_e'(code[2:0]);
            t_rm[n_lines]     = rm[2:0];
            t_a[n_lines]      = a;
            t_b[n_lines]      = b;
            t_result[n_lines] = res;
            t_status[n_lines] = fp_status_t'(st[4:0]);
            n_lines++;
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input fp_word_t exp, input fp_word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: result expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_status(input string name, input fp_status_t exp,
                                input fp_status_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: status expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_tag(input string name, input trans_id_t exp, input trans_id_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: tag expected %0d, actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    // Result handshake happens at the coming rising edge
    task automatic watch_output();
        int        idx;
        trans_id_t tag;
        if (!(fpu_valid_o && out_ready_i)) return;
        if (exp_idx.size() == 0) begin
            $display("Result with tag %0d arrived with no instruction outstanding",
                     fpu_trans_id_o);
            other_errors++;
            return;
        end
        idx = exp_idx.pop_front();
        tag = exp_tag.pop_front();
        check_word(t_name[idx], t_result[idx], result_o);
        check_status(t_name[idx], t_status[idx], fpu_status_o);
        check_tag(t_name[idx], tag, fpu_trans_id_o);
        results_seen++;
    endtask

    // ------------------------------------------------------------------
    // Cycle, issue and drain
    // ------------------------------------------------------------------
    // Drive on the falling edge and sample 1 ns later when all is settled
    task automatic next_cycle(input logic valid, input int idx, input logic do_flush);
        @(negedge clk);
        fpu_valid_i = valid;
        flush_i     = do_flush;
        if (valid) begin
            operator_i  = t_op[idx];
            fpu_rm_i    = t_rm[idx];
            operand_a_i = t_a[idx];
            operand_b_i = t_b[idx];
            trans_id_i  = next_tag;
        end
        out_ready_i = next_out_ready();
        #1;
        watch_output();
    endtask

    // Valid without ready means offer the same instruction again
    task automatic issue(input int idx);
        int waited;
        waited = 0;
        if (timed_out) return;
        next_cycle(1'b1, idx, 1'b0);
        while (!fpu_ready_o) begin
            if (waited == WAIT_LIMIT) begin
                $display("Instruction %s was not accepted within %0d cycles",
                         t_name[idx], WAIT_LIMIT);
                timed_out = 1'b1;
                return;
            end
            waited++;
            next_cycle(1'b1, idx, 1'b0);
        end
        exp_idx.push_back(idx);
        exp_tag.push_back(next_tag);
        next_tag++;
    endtask

    task automatic run_trace();
        int gap;
        for (int i = 0; i < n_lines; i++) begin
            issue(i);
            gap = lfsr_bit() ? 0 : 1 + int'(lfsr_bit());   // Half back-to-back
            repeat (gap) next_cycle(1'b0, 0, 1'b0);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_idx.size() != 0 && !timed_out) begin
            if (waited == WAIT_LIMIT) begin
                $display("%0d results still outstanding after %0d idle cycles",
                         exp_idx.size(), WAIT_LIMIT);
                timed_out = 1'b1;
            end else begin
                waited++;
                next_cycle(1'b0, 0, 1'b0);
            end
        end
        repeat (4) next_cycle(1'b0, 0, 1'b0);     // Catch stray results
    endtask

    // Fill every stage, park one more, then flush them all
    task automatic flush_in_flight();
        hold_back = 1'b1;
        for (int i = 0; i <= int'(NUM_PIPE_REGS); i++) issue(i);
        next_cycle(1'b1, NUM_PIPE_REGS + 1, 1'b0);
        if (fpu_ready_o) begin
            $display("fpu_ready_o stayed high although every stage was occupied");
            other_errors++;
        end
        next_cycle(1'b0, 0, 1'b1);
        exp_idx.delete();           // Nothing may come back
        exp_tag.delete();
        hold_back = 1'b0;
        next_cycle(1'b0, 0, 1'b0);
        if (fpu_valid_o) begin
            $display("fpu_valid_o still high after the flush");
            other_errors++;
        end
    endtask

    initial begin
        reset_i      = 1'b1;
        flush_i      = 1'b0;
        fpu_valid_i  = 1'b0;
        out_ready_i  = 1'b0;
        operator_i   = FSGNJ;
        fpu_rm_i     = '0;
        operand_a_i  = '0;
        operand_b_i  = '0;
        trans_id_i   = '0;
        next_tag     = '0;
        lfsr_q       = 20'd95240;
        hold_back    = 1'b0;
        timed_out    = 1'b0;
        value_errors = 0;
        other_errors = 0;
        results_seen = 0;
        load_trace();
        if (n_lines < int'(NUM_PIPE_REGS) + 2) begin
            $display("The trace holds only %0d usable lines", n_lines);
            other_errors++;
        end
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        run_trace();
        drain();
        flush_in_flight();
        run_trace();                // Issue resumes after the flush
        drain();

        if (results_seen != 2 * n_lines) begin
            $display("Expected %0d results in total but checked %0d", 2 * n_lines, results_seen);
            other_errors++;
        end
        $display("Value errors %0d, protocol errors %0d, timeouts %0d, results checked %0d",
                 value_errors, other_errors, int'(timed_out), results_seen);
        if (value_errors == 0 && other_errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
